// ==== Bender.yml ====
package:
  name: ksBus

sources:
  - design/ksBusPkg.sv
  - design/ksDevPkg.sv
  - design/ksBusIf.sv
  - design/busArbiter.sv
  - design/memController.sv
  - design/ubaBridge.sv
  - design/ksBusTop.sv
  - target: test
    files:
      - test/tbClock.sv
      - test/ksBusTb.sv

// ==== compile.f ====
design/ksBusPkg.sv
design/ksDevPkg.sv
design/ksBusIf.sv
design/busArbiter.sv
design/memController.sv
design/ubaBridge.sv
design/ksBusTop.sv
test/tbClock.sv
test/ksBusTb.sv

// ==== design/busArbiter.sv ====
`timescale 1ns/100ps

module busArbiter
(
   input logic    clk,
   input logic    arstN,
   ksBusIf.slave  cslBus,                     // Console, top priority
   ksBusIf.slave  uba1Bus,
   ksBusIf.slave  uba3Bus,
   ksBusIf.slave  cpuBus,                     // Lowest priority
   ksBusIf.master memBus,
   ksBusIf.master uba1Reg,
   ksBusIf.master uba3Reg
);

   import ksBusPkg::*;
   import ksDevPkg::*;

   typedef enum logic {arbIdle, arbBusy} arbState_t;

   arbState_t state;
   masterId_t grant;                          // Owner of the bus
   masterId_t nextGrant;                      // Priority pick
   slaveId_t  slaveSel;
   logic      pending;                        // Slave has not taken it yet
   logic      slvTaken;
   logic      respValid;
   busWord_t  respData;
   busOp_t    reqOp;
   busWord_t  reqAddr;
   busWord_t  reqWdata;

   // Memory, one of the adapters, or nobody
   function automatic slaveId_t decodeSlave(busWord_t a);
      logic [3:0] ctl;
      ctl = a[ioCtlHi:ioCtlLo];
      if (!a[flagIoCycle])
         return slvMem;
      if (a[flagWru])
         return slvNone;                      // WRU is never claimed
      if (ctl == uba1Num)
         return slvUba1;
      if (ctl == uba3Num)
         return slvUba3;
      return slvNone;
   endfunction

   ////////////////////
   // Arbitration
   ////////////////////

   always_comb
   begin
      if (cslBus.reqValid)
         nextGrant = mstCsl;
      else if (uba1Bus.reqValid)
         nextGrant = mstUba1;
      else if (uba3Bus.reqValid)
         nextGrant = mstUba3;
      else if (cpuBus.reqValid)
         nextGrant = mstCpu;
      else
         nextGrant = mstNone;
   end

   // Ready only to the winner, only when idle
   assign cslBus.reqReady  = (state == arbIdle) && (nextGrant == mstCsl);
   assign uba1Bus.reqReady = (state == arbIdle) && (nextGrant == mstUba1);
   assign uba3Bus.reqReady = (state == arbIdle) && (nextGrant == mstUba3);
   assign cpuBus.reqReady  = (state == arbIdle) && (nextGrant == mstCpu);

   // Capture the winning request
   always_ff @(posedge clk)
   begin
      if (state == arbIdle)
      begin
         case (nextGrant)
            mstCsl:
            begin
               reqOp    <= cslBus.op;
               reqAddr  <= cslBus.addr;
               reqWdata <= cslBus.wdata;
            end
            mstUba1:
            begin
               reqOp    <= uba1Bus.op;
               reqAddr  <= uba1Bus.addr;
               reqWdata <= uba1Bus.wdata;
            end
            mstUba3:
            begin
               reqOp    <= uba3Bus.op;
               reqAddr  <= uba3Bus.addr;
               reqWdata <= uba3Bus.wdata;
            end
            default:
            begin
               reqOp    <= cpuBus.op;
               reqAddr  <= cpuBus.addr;
               reqWdata <= cpuBus.wdata;
            end
         endcase
      end
   end

   assign slaveSel = decodeSlave(reqAddr);
   assign slvTaken = (memBus.reqValid & memBus.reqReady) |
                     (uba1Reg.reqValid & uba1Reg.reqReady) |
                     (uba3Reg.reqValid & uba3Reg.reqReady);

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         state   <= arbIdle;
         grant   <= mstNone;
         pending <= 1'b0;
      end
      else if (state == arbIdle)
      begin
         if (nextGrant != mstNone)
         begin
            state   <= arbBusy;
            grant   <= nextGrant;
            pending <= 1'b1;
         end
      end
      else
      begin
         if (slvTaken)
            pending <= 1'b0;
         if (respValid)                       // Transaction done
         begin
            state   <= arbIdle;
            grant   <= mstNone;
            pending <= 1'b0;
         end
      end
   end

   ////////////////////
   // Slave side
   ////////////////////

   assign memBus.reqValid  = (state == arbBusy) && pending && (slaveSel == slvMem);
   assign uba1Reg.reqValid = (state == arbBusy) && pending && (slaveSel == slvUba1);
   assign uba3Reg.reqValid = (state == arbBusy) && pending && (slaveSel == slvUba3);

   assign memBus.op     = reqOp;
   assign memBus.addr   = reqAddr;
   assign memBus.wdata  = reqWdata;
   assign uba1Reg.op    = reqOp;
   assign uba1Reg.addr  = reqAddr;
   assign uba1Reg.wdata = reqWdata;
   assign uba3Reg.op    = reqOp;
   assign uba3Reg.addr  = reqAddr;
   assign uba3Reg.wdata = reqWdata;

   // Response path back toward the owner
   always_comb
   begin
      respValid = 1'b0;
      respData  = '0;                         // Zero for unclaimed cycles
      if (state == arbBusy)
      begin
         case (slaveSel)
            slvMem:
            begin
               respValid = memBus.rspValid;
               respData  = memBus.rdata;
            end
            slvUba1:
            begin
               respValid = uba1Reg.rspValid;
               respData  = uba1Reg.rdata;
            end
            slvUba3:
            begin
               respValid = uba3Reg.rspValid;
               respData  = uba3Reg.rdata;
            end
            default: respValid = 1'b1;        // Default responder
         endcase
      end
   end

   assign cslBus.rspValid  = respValid && (grant == mstCsl);
   assign uba1Bus.rspValid = respValid && (grant == mstUba1);
   assign uba3Bus.rspValid = respValid && (grant == mstUba3);
   assign cpuBus.rspValid  = respValid && (grant == mstCpu);
   assign cslBus.rdata     = respData;
   assign uba1Bus.rdata    = respData;
   assign uba3Bus.rdata    = respData;
   assign cpuBus.rdata     = respData;

   ////////////////////
   // Checks
   ////////////////////

   aOneReady: assert property (@(posedge clk) disable iff (!arstN)
      $onehot0({cslBus.reqReady, uba1Bus.reqReady, uba3Bus.reqReady, cpuBus.reqReady}));

   // Owner cannot change mid-transaction
   aGrantHeld: assert property (@(posedge clk) disable iff (!arstN)
      (state == arbBusy) && !respValid |=> $stable(grant));

   aNoStrayRsp: assert property (@(posedge clk) disable iff (!arstN)
      (state == arbIdle) |-> !(memBus.rspValid || uba1Reg.rspValid || uba3Reg.rspValid));

endmodule

// ==== design/ksBusIf.sv ====
`timescale 1ns/100ps

interface ksBusIf;

   import ksBusPkg::*;

   // Request channel
   logic     reqValid;
   logic     reqReady;
   busOp_t   op;
   busWord_t addr;
   busWord_t wdata;                           // Ignored on reads

   // Response strobe, never held off
   logic     rspValid;
   busWord_t rdata;

   modport master
   (
      output reqValid,
      output op,
      output addr,
      output wdata,
      input  reqReady,
      input  rspValid,
      input  rdata
   );

   modport slave
   (
      input  reqValid,
      input  op,
      input  addr,
      input  wdata,
      output reqReady,
      output rspValid,
      output rdata
   );

endinterface

// ==== design/ksBusPkg.sv ====
package ksBusPkg;

   ////////////////////
   // Word format
   ////////////////////

   localparam int wordWidth = 36;             // One KS10 word

   // Bit 0 is the MSB, KS10 numbering
   typedef logic [0:wordWidth-1] busWord_t;

   typedef enum logic
   {
      busRead  = 1'b0,
      busWrite = 1'b1
   } busOp_t;

   ////////////////////
   // Address flags
   ////////////////////

   localparam int flagPhysical = 8;           // Physical reference
   localparam int flagIoCycle  = 10;          // IO space, not memory
   localparam int flagWru      = 11;          // Who-Are-You cycle

   // IO address layout
   localparam int ioCtlHi = 14;               // Controller number MSB
   localparam int ioCtlLo = 17;               // Controller number LSB
   localparam int ioRegHi = 33;               // Register index MSB
   localparam int ioRegLo = 35;

   // Memory word index counts up from here toward bit 0
   localparam int memAddrLo = 35;

endpackage

// ==== design/ksBusTop.sv ====
`timescale 1ns/100ps

module ksBusTop
(
   input  logic               clk,
   input  logic               arstN,
   // Console master
   input  logic               cslReqValid,
   output logic               cslReqReady,
   input  ksBusPkg::busOp_t   cslOp,
   input  ksBusPkg::busWord_t cslAddr,
   input  ksBusPkg::busWord_t cslWdata,
   output logic               cslRspValid,
   output ksBusPkg::busWord_t cslRdata,
   // CPU master
   input  logic               cpuReqValid,
   output logic               cpuReqReady,
   input  ksBusPkg::busOp_t   cpuOp,
   input  ksBusPkg::busWord_t cpuAddr,
   input  ksBusPkg::busWord_t cpuWdata,
   output logic               cpuRspValid,
   output ksBusPkg::busWord_t cpuRdata,
   // Unibus 1 device DMA
   input  logic               uba1DmaValid,
   output logic               uba1DmaReady,
   input  ksBusPkg::busOp_t   uba1DmaOp,
   input  ksBusPkg::busWord_t uba1DmaAddr,
   input  ksBusPkg::busWord_t uba1DmaWdata,
   output logic               uba1DmaRspValid,
   output ksBusPkg::busWord_t uba1DmaRdata,
   // Unibus 3 device DMA
   input  logic               uba3DmaValid,
   output logic               uba3DmaReady,
   input  ksBusPkg::busOp_t   uba3DmaOp,
   input  ksBusPkg::busWord_t uba3DmaAddr,
   input  ksBusPkg::busWord_t uba3DmaWdata,
   output logic               uba3DmaRspValid,
   output ksBusPkg::busWord_t uba3DmaRdata
);

   import ksDevPkg::*;

   ksBusIf cslBus();                          // Master side
   ksBusIf cpuBus();
   ksBusIf uba1Dma();
   ksBusIf uba3Dma();
   ksBusIf memBus();                          // Slave side
   ksBusIf uba1Reg();
   ksBusIf uba3Reg();

   ////////////////////
   // Plain ports to channels
   ////////////////////

   assign cslBus.reqValid = cslReqValid;
   assign cslBus.op       = cslOp;
   assign cslBus.addr     = cslAddr;
   assign cslBus.wdata    = cslWdata;
   assign cslReqReady     = cslBus.reqReady;
   assign cslRspValid     = cslBus.rspValid;
   assign cslRdata        = cslBus.rdata;

   assign cpuBus.reqValid = cpuReqValid;
   assign cpuBus.op       = cpuOp;
   assign cpuBus.addr     = cpuAddr;
   assign cpuBus.wdata    = cpuWdata;
   assign cpuReqReady     = cpuBus.reqReady;
   assign cpuRspValid     = cpuBus.rspValid;
   assign cpuRdata        = cpuBus.rdata;

   busArbiter busArbiter_inst
   (
      .clk(clk),
      .arstN(arstN),
      .cslBus(cslBus),
      .uba1Bus(uba1Dma),
      .uba3Bus(uba3Dma),
      .cpuBus(cpuBus),
      .memBus(memBus),
      .uba1Reg(uba1Reg),
      .uba3Reg(uba3Reg)
   );

   memController memController_inst
   (
      .clk(clk),
      .arstN(arstN),
      .bus(memBus)
   );

   ubaBridge #(.ubaNum(uba1Num)) uba1Bridge_inst
   (
      .clk(clk),
      .arstN(arstN),
      .regBus(uba1Reg),
      .dmaBus(uba1Dma),
      .dmaValid(uba1DmaValid),
      .dmaReady(uba1DmaReady),
      .dmaOp(uba1DmaOp),
      .dmaAddr(uba1DmaAddr),
      .dmaWdata(uba1DmaWdata),
      .dmaRspValid(uba1DmaRspValid),
      .dmaRdata(uba1DmaRdata)
   );

   ubaBridge #(.ubaNum(uba3Num)) uba3Bridge_inst
   (
      .clk(clk),
      .arstN(arstN),
      .regBus(uba3Reg),
      .dmaBus(uba3Dma),
      .dmaValid(uba3DmaValid),
      .dmaReady(uba3DmaReady),
      .dmaOp(uba3DmaOp),
      .dmaAddr(uba3DmaAddr),
      .dmaWdata(uba3DmaWdata),
      .dmaRspValid(uba3DmaRspValid),
      .dmaRdata(uba3DmaRdata)
   );

endmodule

// ==== design/ksDevPkg.sv ====
package ksDevPkg;

   // Bus owner, listed in priority order
   typedef enum logic [2:0]
   {
      mstCsl,
      mstUba1,
      mstUba3,
      mstCpu,
      mstNone                                 // Bus free
   } masterId_t;

   typedef enum logic [1:0]
   {
      slvMem,
      slvUba1,
      slvUba3,
      slvNone                                 // Arbiter answers with zero
   } slaveId_t;

   // Main memory
   localparam int memWords   = 1024;
   localparam int memIdxBits = 10;            // log2 of memWords

   // Unibus adapters
   localparam int         ubaRegs = 8;        // Register bank depth
   localparam logic [3:0] uba1Num = 4'd1;
   localparam logic [3:0] uba3Num = 4'd3;

endpackage

// ==== design/memController.sv ====
`timescale 1ns/100ps

module memController
(
   input logic   clk,
   input logic   arstN,
   ksBusIf.slave bus
);

   import ksBusPkg::*;
   import ksDevPkg::*;

   busWord_t              memArray [memWords];
   logic [memIdxBits-1:0] wordIdx;
   logic                  accept;
   logic                  s1Valid;            // First delay stage
   logic                  s2Valid;            // Response stage
   busWord_t              s1Data;
   busWord_t              s2Data;

   // Low address bits pick the word
   assign wordIdx = bus.addr[memAddrLo -: memIdxBits];

   assign bus.reqReady = !(s1Valid || s2Valid);   // One access at a time
   assign accept       = bus.reqValid && bus.reqReady;

   ////////////////////
   // Array and data pipe
   ////////////////////

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         if (bus.op == busWrite)
            memArray[wordIdx] <= bus.wdata;
         s1Data <= memArray[wordIdx];         // Old contents on writes
      end
      s2Data <= s1Data;
   end

   // Valid bits follow the data two cycles out
   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         s1Valid <= 1'b0;
         s2Valid <= 1'b0;
      end
      else
      begin
         s1Valid <= accept;
         s2Valid <= s1Valid;
      end
   end

   assign bus.rspValid = s2Valid;
   assign bus.rdata    = s2Data;

   // Arbiter keeps one transaction in flight
   aNoOverlap: assert property (@(posedge clk) disable iff (!arstN)
      (s1Valid || s2Valid) |-> !bus.reqValid);

endmodule

// ==== design/ubaBridge.sv ====
`timescale 1ns/100ps

module ubaBridge
#(
   parameter logic [3:0] ubaNum = 4'd1        // Controller number
)
(
   input  logic              clk,
   input  logic              arstN,
   ksBusIf.slave             regBus,          // IO cycles from the arbiter
   ksBusIf.master            dmaBus,          // DMA toward memory
   input  logic              dmaValid,
   output logic              dmaReady,
   input  ksBusPkg::busOp_t   dmaOp,
   input  ksBusPkg::busWord_t dmaAddr,
   input  ksBusPkg::busWord_t dmaWdata,
   output logic              dmaRspValid,
   output ksBusPkg::busWord_t dmaRdata
);

   import ksBusPkg::*;
   import ksDevPkg::*;

   busWord_t                   regBank [ubaRegs];
   logic [$clog2(ubaRegs)-1:0] regIdx;
   logic                       regAccept;
   logic                       regRsp;       // Response due this cycle
   busWord_t                   regRdata;
   logic                       holdFull;
   logic                       holdSent;     // Request went out, awaiting rsp
   busOp_t                     holdOp;
   busWord_t                   holdAddr;
   busWord_t                   holdWdata;

   ////////////////////
   // Register port
   ////////////////////

   assign regIdx          = regBus.addr[ioRegHi:ioRegLo];
   assign regBus.reqReady = !regRsp;
   assign regAccept       = regBus.reqValid && regBus.reqReady;

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         for (int i = 0; i < ubaRegs; i++)
            regBank[i] <= '0;
         regBank[0] <= busWord_t'(ubaNum);    // Identity register
         regRsp     <= 1'b0;
      end
      else
      begin
         if (regAccept && (regBus.op == busWrite))
            regBank[regIdx] <= regBus.wdata;
         regRsp <= regAccept;
      end
   end

   always_ff @(posedge clk)
   begin
      if (regAccept)
         regRdata <= regBank[regIdx];
   end

   assign regBus.rspValid = regRsp;
   assign regBus.rdata    = regRdata;

   ////////////////////
   // DMA path
   ////////////////////

   assign dmaReady = !holdFull;

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         holdFull <= 1'b0;
         holdSent <= 1'b0;
      end
      else if (dmaValid && dmaReady)
         holdFull <= 1'b1;
      else if (dmaBus.rspValid)
      begin
         holdFull <= 1'b0;
         holdSent <= 1'b0;
      end
      else if (dmaBus.reqValid && dmaBus.reqReady)
         holdSent <= 1'b1;
   end

   // DMA only reaches memory, so strip the IO flags
   always_ff @(posedge clk)
   begin
      if (dmaValid && dmaReady)
      begin
         holdOp                <= dmaOp;
         holdAddr              <= dmaAddr;
         holdAddr[flagIoCycle] <= 1'b0;
         holdAddr[flagWru]     <= 1'b0;
         holdWdata             <= dmaWdata;
      end
   end

   assign dmaBus.reqValid = holdFull && !holdSent;
   assign dmaBus.op       = holdOp;
   assign dmaBus.addr     = holdAddr;
   assign dmaBus.wdata    = holdWdata;
   assign dmaRspValid     = dmaBus.rspValid;
   assign dmaRdata        = dmaBus.rdata;

   // Held request survives until its response
   aHoldStable: assert property (@(posedge clk) disable iff (!arstN)
      holdFull && !dmaBus.rspValid |=> holdFull && $stable(holdAddr) && $stable(holdOp));

   aOwnCtl: assert property (@(posedge clk) disable iff (!arstN)
      regAccept |-> regBus.addr[ioCtlHi:ioCtlLo] == ubaNum);

endmodule

// ==== test/ksBusTb.sv ====
`timescale 1ns/100ps

module ksBusTb;

   import ksBusPkg::*;
   import ksDevPkg::*;

   typedef enum logic [1:0] {portCsl, portCpu, portUba1, portUba3} port_t;
   typedef enum logic [1:0] {expCalc, expZero, expUbaNum} expMode_t;
   typedef enum logic [1:0] {tgtMem, tgtUba1, tgtUba3, tgtNone} target_t;

   // One stimulus row
   typedef struct packed
   {
      port_t    port;
      busOp_t   op;
      busWord_t addr;
      busWord_t wdata;                        // Random on writes
      expMode_t mode;
   } row_t;

   localparam int maxWait = 64;               // Cycles allowed per wait loop
   localparam int idxMsb  = memAddrLo - memIdxBits + 1;

   logic     clk;
   logic     arstN;
   logic     cslReqValid, cslReqReady, cslRspValid;
   busOp_t   cslOp;
   busWord_t cslAddr, cslWdata, cslRdata;
   logic     cpuReqValid, cpuReqReady, cpuRspValid;
   busOp_t   cpuOp;
   busWord_t cpuAddr, cpuWdata, cpuRdata;
   logic     uba1DmaValid, uba1DmaReady, uba1DmaRspValid;
   busOp_t   uba1DmaOp;
   busWord_t uba1DmaAddr, uba1DmaWdata, uba1DmaRdata;
   logic     uba3DmaValid, uba3DmaReady, uba3DmaRspValid;
   busOp_t   uba3DmaOp;
   busWord_t uba3DmaAddr, uba3DmaWdata, uba3DmaRdata;

   // Reference model
   busWord_t refMem [memWords];
   busWord_t refReg1 [ubaRegs];
   busWord_t refReg3 [ubaRegs];

   row_t     rows [$];
   int       cycleCnt = 0;                    // Counts falling edges
   int       errCount;
   int       testCount;
   int       passCount;
   int       errBefore;
   int       accCyc;
   int       rspCyc;
   int       lat;
   bit       done;
   busWord_t gotData;
   busWord_t expData;
   busWord_t ctData [4];                      // Contention: csl, uba1, cpu, then uba3
   busWord_t ctExp [4];
   int       ctAcc [4];
   int       ctRsp [4];
   bit       ctOk [4];

   tbClock #(.periodNs(40)) tbClock_inst (.clk(clk));

   // Port names match one to one
   ksBusTop ksBusTop_inst (.*);

   always @(negedge clk)
      cycleCnt++;

   ////////////////////
   // Addresses
   ////////////////////

   function automatic busWord_t memAddr(int idx);
      busWord_t a;
      a = '0;
      a[flagPhysical] = 1'b1;
      a[idxMsb:memAddrLo] = idx[memIdxBits-1:0];
      return a;
   endfunction

   function automatic busWord_t ioAddr(int ctl, int regNo);
      busWord_t a;
      a = '0;
      a[flagPhysical] = 1'b1;
      a[flagIoCycle]  = 1'b1;
      a[ioCtlHi:ioCtlLo] = ctl[3:0];
      a[ioRegHi:ioRegLo] = regNo[2:0];
      return a;
   endfunction

   function automatic busWord_t wruAddr(int ctl);
      busWord_t a;
      a = ioAddr(ctl, 0);
      a[flagWru] = 1'b1;                      // Nobody claims it
      return a;
   endfunction

   // Memory word with IO flags set, as a confused device might send
   function automatic busWord_t dmaIoAddr(int idx);
      busWord_t a;
      a = memAddr(idx);
      a[flagIoCycle] = 1'b1;
      a[flagWru]     = 1'b1;
      a[ioCtlHi:ioCtlLo] = 4'd3;
      return a;
   endfunction

   function automatic busWord_t randomWord();
      logic [63:0] r;
      r = {$urandom(), $urandom()};
      return r[35:0];
   endfunction

   ////////////////////
   // Model
   ////////////////////

   function automatic target_t targetOf(port_t port, busWord_t addr);
      logic [3:0] ctl;
      ctl = addr[ioCtlHi:ioCtlLo];
      if (port == portUba1 || port == portUba3 || !addr[flagIoCycle])
         return tgtMem;                       // DMA always lands in memory
      if (addr[flagWru])
         return tgtNone;
      if (ctl == uba1Num)
         return tgtUba1;
      if (ctl == uba3Num)
         return tgtUba3;
      return tgtNone;
   endfunction

   // Idle-bus cycles from ready to response
   function automatic int expLatency(port_t port, busWord_t addr);
      if (port == portUba1 || port == portUba3)
         return 0;                            // Holding stage in the way, not timed
      case (targetOf(port, addr))
         tgtMem:  return 3;
         tgtUba1: return 2;
         tgtUba3: return 2;
         default: return 1;
      endcase
   endfunction

   // Returns read data, applies writes
   function automatic busWord_t modelAccess(port_t port, busOp_t op, busWord_t addr,
                                            busWord_t wdata);
      logic [memIdxBits-1:0] idx;
      logic [2:0]            regIdx;
      busWord_t              old;
      idx    = addr[idxMsb:memAddrLo];
      regIdx = addr[ioRegHi:ioRegLo];
      old    = '0;                            // Unclaimed IO reads zero
      case (targetOf(port, addr))
         tgtMem:
         begin
            old = refMem[idx];
            if (op == busWrite)
               refMem[idx] = wdata;
         end
         tgtUba1:
         begin
            old = refReg1[regIdx];
            if (op == busWrite)
               refReg1[regIdx] = wdata;
         end
         tgtUba3:
         begin
            old = refReg3[regIdx];
            if (op == busWrite)
               refReg3[regIdx] = wdata;
         end
         default: ;
      endcase
      return old;
   endfunction

   ////////////////////
   // Port access
   ////////////////////

   task automatic driveReq(port_t port, logic valid, busOp_t op, busWord_t addr,
                           busWord_t wdata);
      case (port)
         portCsl:
         begin
            cslReqValid = valid;
            cslOp       = op;
            cslAddr     = addr;
            cslWdata    = wdata;
         end
         portCpu:
         begin
            cpuReqValid = valid;
            cpuOp       = op;
            cpuAddr     = addr;
            cpuWdata    = wdata;
         end
         portUba1:
         begin
            uba1DmaValid = valid;
            uba1DmaOp    = op;
            uba1DmaAddr  = addr;
            uba1DmaWdata = wdata;
         end
         default:
         begin
            uba3DmaValid = valid;
            uba3DmaOp    = op;
            uba3DmaAddr  = addr;
            uba3DmaWdata = wdata;
         end
      endcase
   endtask

   function automatic logic readyOf(port_t port);
      case (port)
         portCsl:  return cslReqReady;
         portCpu:  return cpuReqReady;
         portUba1: return uba1DmaReady;
         default:  return uba3DmaReady;
      endcase
   endfunction

   function automatic logic rspOf(port_t port);
      case (port)
         portCsl:  return cslRspValid;
         portCpu:  return cpuRspValid;
         portUba1: return uba1DmaRspValid;
         default:  return uba3DmaRspValid;
      endcase
   endfunction

   function automatic busWord_t rdataOf(port_t port);
      case (port)
         portCsl:  return cslRdata;
         portCpu:  return cpuRdata;
         portUba1: return uba1DmaRdata;
         default:  return uba3DmaRdata;
      endcase
   endfunction

   function automatic string portName(port_t port);
      case (port)
         portCsl:  return "csl";
         portCpu:  return "cpu";
         portUba1: return "uba1 dma";
         default:  return "uba3 dma";
      endcase
   endfunction

   // One full transaction, cycle stamps taken 1 ns after each falling edge
   task automatic runRequest(input port_t port, input busOp_t op, input busWord_t addr,
                             input busWord_t wdata, output busWord_t rdata,
                             output int accStamp, output int rspStamp, output bit ok);
      int waitCnt;
      bit seen;
      rdata    = '0;
      accStamp = -1;
      rspStamp = -1;
      ok       = 1'b0;
      @(negedge clk);
      driveReq(port, 1'b1, op, addr, wdata);
      seen    = 1'b0;
      waitCnt = 0;
      while (!seen && waitCnt < maxWait)
      begin
         #1;
         seen = readyOf(port);                // Combinational, stable until rising edge
         if (!seen)
         begin
            waitCnt++;
            @(negedge clk);
         end
      end
      if (!seen)
      begin
         driveReq(port, 1'b0, busRead, '0, '0);
         $display("Timeout: %s request was never accepted", portName(port));
         errCount++;
         return;
      end
      accStamp = cycleCnt;
      @(negedge clk);                         // Transferred on the rising edge
      driveReq(port, 1'b0, busRead, '0, '0);
      seen    = 1'b0;
      waitCnt = 0;
      while (!seen && waitCnt < maxWait)
      begin
         #1;
         seen = rspOf(port);
         if (!seen)
         begin
            waitCnt++;
            @(negedge clk);
         end
      end
      if (!seen)
      begin
         $display("Timeout: %s request got no response", portName(port));
         errCount++;
         return;
      end
      rspStamp = cycleCnt;
      rdata    = rdataOf(port);
      ok       = 1'b1;
   endtask

   ////////////////////
   // Checks and report
   ////////////////////

   task automatic checkQuiet(string when);
      assert (!(cslReqReady || cslRspValid || cpuReqReady || cpuRspValid ||
                uba1DmaRspValid || uba3DmaRspValid))
      else
      begin
         $display("FAIL at %0t ns: ready or response high %s", $time, when);
         errCount++;
      end
      // Empty holding registers
      assert (uba1DmaReady && uba3DmaReady)
      else
      begin
         $display("FAIL at %0t ns: DMA ready low %s", $time, when);
         errCount++;
      end
   endtask

   task automatic reportTest(string name, bit ok);
      testCount++;
      if (ok)
      begin
         passCount++;
         $display("%s: passed", name);
      end
      else
         $display("%s: failed", name);
   endtask

   function automatic void addRow(port_t port, busOp_t op, busWord_t addr, expMode_t mode);
      row_t r;
      r.port  = port;
      r.op    = op;
      r.addr  = addr;
      r.wdata = (op == busWrite) ? randomWord() : '0;
      r.mode  = mode;
      rows.push_back(r);
   endfunction

   task automatic buildTable();
      addRow(portCpu,  busWrite, memAddr(5),       expCalc);   // Memory from both masters
      addRow(portCsl,  busWrite, memAddr(12),      expCalc);
      addRow(portCpu,  busWrite, memAddr(1023),    expCalc);
      addRow(portCpu,  busRead,  memAddr(5),       expCalc);
      addRow(portCsl,  busRead,  memAddr(12),      expCalc);
      addRow(portCsl,  busRead,  memAddr(5),       expCalc);
      addRow(portCpu,  busRead,  memAddr(1023),    expCalc);
      addRow(portCpu,  busRead,  ioAddr(1, 0),     expUbaNum); // Identity registers
      addRow(portCsl,  busRead,  ioAddr(3, 0),     expUbaNum);
      addRow(portCpu,  busWrite, ioAddr(1, 2),     expCalc);
      addRow(portCsl,  busWrite, ioAddr(3, 2),     expCalc);
      addRow(portCpu,  busRead,  ioAddr(1, 2),     expCalc);
      addRow(portCpu,  busRead,  ioAddr(3, 2),     expCalc);
      addRow(portCsl,  busWrite, ioAddr(3, 7),     expCalc);
      addRow(portCsl,  busRead,  ioAddr(3, 7),     expCalc);
      addRow(portCpu,  busRead,  ioAddr(1, 7),     expCalc);   // Other bank untouched
      addRow(portCpu,  busRead,  wruAddr(1),       expZero);
      addRow(portCpu,  busRead,  ioAddr(5, 0),     expZero);   // No such controller
      addRow(portCsl,  busWrite, ioAddr(6, 1),     expCalc);
      addRow(portUba1, busWrite, memAddr(40),      expCalc);   // DMA toward memory
      addRow(portUba3, busWrite, dmaIoAddr(41),    expCalc);
      addRow(portUba1, busWrite, dmaIoAddr(42),    expCalc);
      addRow(portCpu,  busRead,  memAddr(40),      expCalc);
      addRow(portCpu,  busRead,  memAddr(41),      expCalc);
      addRow(portUba3, busRead,  memAddr(12),      expCalc);
      addRow(portUba1, busRead,  dmaIoAddr(1023),  expCalc);
      addRow(portCsl,  busRead,  memAddr(42),      expCalc);
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial
   begin
      void'($urandom(82483));
      $timeformat(-9, 0, "", 0);
      errCount  = 0;
      testCount = 0;
      passCount = 0;
      arstN     = 1'b0;
      for (int p = 0; p < 4; p++)
         driveReq(port_t'(p), 1'b0, busRead, '0, '0);
      for (int k = 0; k < ubaRegs; k++)
      begin
         refReg1[k] = '0;
         refReg3[k] = '0;
      end
      refReg1[0] = busWord_t'(uba1Num);       // Register 0 holds the controller number
      refReg3[0] = busWord_t'(uba3Num);
      buildTable();

      // Reset, 16 cycles
      errBefore = errCount;
      repeat (15)
      begin
         @(negedge clk);
         #1;
         checkQuiet("during reset");
      end
      @(negedge clk);
      arstN = 1'b1;
      repeat (3)
      begin
         @(negedge clk);
         #1;
         checkQuiet("after reset");
      end
      reportTest("reset outputs", errCount == errBefore);

      foreach (rows[i])
      begin
         errBefore = errCount;
         expData = modelAccess(rows[i].port, rows[i].op, rows[i].addr, rows[i].wdata);
         if (rows[i].mode == expZero)
            expData = '0;
         else if (rows[i].mode == expUbaNum)
            expData = busWord_t'(rows[i].addr[ioCtlHi:ioCtlLo]);
         runRequest(rows[i].port, rows[i].op, rows[i].addr, rows[i].wdata,
                    gotData, accCyc, rspCyc, done);
         lat = expLatency(rows[i].port, rows[i].addr);
         if (done && rows[i].op == busRead)
         begin
            assert (gotData === expData)
            else
            begin
               $display("FAIL at %0t ns: row %0d read %h, expected %h", $time, i + 1,
                        gotData, expData);
               errCount++;
            end
         end
         if (done && lat != 0)
         begin
            assert (rspCyc - accCyc == lat)
            else
            begin
               $display("FAIL at %0t ns: row %0d took %0d cycles, expected %0d", $time,
                        i + 1, rspCyc - accCyc, lat);
               errCount++;
            end
         end
         reportTest($sformatf("row %0d %s %s %h", i + 1, portName(rows[i].port),
                              (rows[i].op == busWrite) ? "write" : "read", rows[i].addr),
                    errCount == errBefore);
      end

      // Three masters on the same falling edge, while uba3 DMA holds the bus
      errBefore = errCount;
      ctExp[0] = modelAccess(portCsl, busRead, memAddr(5), '0);
      ctExp[1] = modelAccess(portUba1, busRead, memAddr(41), '0);
      ctExp[2] = modelAccess(portCpu, busRead, memAddr(42), '0);
      ctExp[3] = modelAccess(portUba3, busRead, memAddr(40), '0);
      fork
         runRequest(portUba3, busRead, memAddr(40), '0, ctData[3], ctAcc[3], ctRsp[3],
                    ctOk[3]);
         begin
            repeat (2)
               @(negedge clk);                // Uba3 owns the bus by now
            fork
               runRequest(portCsl, busRead, memAddr(5), '0, ctData[0], ctAcc[0], ctRsp[0],
                          ctOk[0]);
               runRequest(portUba1, busRead, memAddr(41), '0, ctData[1], ctAcc[1], ctRsp[1],
                          ctOk[1]);
               runRequest(portCpu, busRead, memAddr(42), '0, ctData[2], ctAcc[2], ctRsp[2],
                          ctOk[2]);
            join
         end
      join
      for (int k = 0; k < 4; k++)
      begin
         if (ctOk[k])
         begin
            assert (ctData[k] === ctExp[k])
            else
            begin
               $display("FAIL at %0t ns: contention read %0d got %h, expected %h", $time, k,
                        ctData[k], ctExp[k]);
               errCount++;
            end
         end
      end
      // Uba1 must finish on the bus before the CPU gets its ready
      assert (ctAcc[0] < ctAcc[2] && ctRsp[0] < ctRsp[1] && ctRsp[1] < ctAcc[2])
      else
      begin
         $display("FAIL at %0t ns: grant order wrong, csl %0d/%0d uba1 %0d cpu %0d", $time,
                  ctAcc[0], ctRsp[0], ctRsp[1], ctAcc[2]);
         errCount++;
      end
      reportTest("priority csl, uba1, cpu", errCount == errBefore);

      $display("Tests %0d, passed %0d, failed %0d, errors %0d", testCount, passCount,
               testCount - passCount, errCount);
      if (errCount == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

// ==== test/tbClock.sv ====
`timescale 1ns/100ps

module tbClock
#(
   parameter int periodNs = 40                // Full clock period
)
(
   output logic clk
);

   initial
   begin
      clk = 1'b0;
      forever
         #(periodNs / 2) clk = ~clk;
   end

endmodule
